// ==== src/arf_pkg.sv ====
`default_nettype none

package arf_pkg;

  parameter int num_arch_regs = 32;
  parameter int reg_sel_w     = 5;
  parameter int data_w        = 32;
  parameter int rrf_tag_w     = 6;
  parameter int max_spec      = 8;  // only the low num_spec bits are live

  typedef logic [reg_sel_w-1:0] reg_idx_t;
  typedef logic [rrf_tag_w-1:0] rrf_tag_t;
  typedef logic [max_spec-1:0]  spec_vec_t;

  // 3 bits leaves room for more resolution kinds
  typedef enum logic [2:0] {
    br_none    = 3'd0,
    br_success = 3'd1,
    br_miss    = 3'd2
  } br_kind_e;

  typedef struct packed {
    br_kind_e  kind;
    spec_vec_t tag;    // one-hot checkpoint
  } branch_res_t;

  typedef struct packed {
    logic     busy;
    rrf_tag_t tag;
  } map_entry_t;

  typedef map_entry_t [num_arch_regs-1:0] map_state_t;

  typedef struct packed {
    reg_idx_t rs1_1;
    reg_idx_t rs2_1;
    reg_idx_t rs1_2;
    reg_idx_t rs2_2;
  } read_addrs_t;

  typedef struct packed {
    logic [data_w-1:0] data;
    rrf_tag_t          tag;
    logic              busy;
  } operand_t;

  typedef struct packed {
    logic              valid;
    reg_idx_t          dst;      // architectural destination
    logic [data_w-1:0] data;
    rrf_tag_t          rrf_tag;
  } commit_t;

  typedef struct packed {
    logic      valid;
    reg_idx_t  dst;
    rrf_tag_t  rrf_tag;
    spec_vec_t mpft_valid;  // 1 = checkpoint j not touched
  } dispatch_t;

endpackage

`default_nettype wire

// ==== src/reg_file.sv ====
`default_nettype none

module reg_file (
  input  wire                            clk,
  input  wire  arf_pkg::read_addrs_t     read_addrs,
  input  wire  arf_pkg::commit_t         commit1,
  input  wire  arf_pkg::commit_t         commit2,
  output logic [arf_pkg::data_w-1:0]     rdata1,
  output logic [arf_pkg::data_w-1:0]     rdata2,
  output logic [arf_pkg::data_w-1:0]     rdata3,
  output logic [arf_pkg::data_w-1:0]     rdata4
);

  logic [arf_pkg::data_w-1:0] mem [arf_pkg::num_arch_regs];

  logic we1;
  logic we2;

  // r0 is hardwired, never written
  assign we1 = commit1.valid && (commit1.dst != '0);
  assign we2 = commit2.valid && (commit2.dst != '0);

  always_ff @(posedge clk) begin
    if (we1) begin
      mem[commit1.dst] <= commit1.data;
    end
    if (we2) begin
      mem[commit2.dst] <= commit2.data;  // last write wins on same reg
    end
  end

  // combinational reads, r0 forced to zero
  always_comb begin
    rdata1 = mem[read_addrs.rs1_1];
    rdata2 = mem[read_addrs.rs2_1];
    rdata3 = mem[read_addrs.rs1_2];
    rdata4 = mem[read_addrs.rs2_2];
    if (read_addrs.rs1_1 == '0) begin
      rdata1 = '0;
    end
    if (read_addrs.rs2_1 == '0) begin
      rdata2 = '0;
    end
    if (read_addrs.rs1_2 == '0) begin
      rdata3 = '0;
    end
    if (read_addrs.rs2_2 == '0) begin
      rdata4 = '0;
    end
  end

endmodule

`default_nettype wire

// ==== src/rename_copy.sv ====
`default_nettype none

module rename_copy (
  input  wire                        clk,
  input  wire                        reset,
  input  wire  arf_pkg::dispatch_t   dispatch1,
  input  wire  arf_pkg::dispatch_t   dispatch2,
  input  wire  [1:0]                 set_en,     // per dispatch port
  input  wire  arf_pkg::commit_t     commit1,
  input  wire  arf_pkg::commit_t     commit2,
  input  wire                        clear_en,
  input  wire                        load,
  input  wire  arf_pkg::map_state_t  load_map,
  output arf_pkg::map_state_t        cur_map,
  output arf_pkg::map_state_t        next_map
);

  logic set1;
  logic set2;
  logic hit1;  // commit1 reg also being set this cycle
  logic hit2;
  logic tag_ok1;
  logic tag_ok2;
  logic clr1;
  logic clr2;

  assign set1 = dispatch1.valid && set_en[0];
  assign set2 = dispatch2.valid && set_en[1];

  assign hit1 = (set1 && (dispatch1.dst == commit1.dst)) ||
                (set2 && (dispatch2.dst == commit1.dst));
  assign hit2 = (set1 && (dispatch1.dst == commit2.dst)) ||
                (set2 && (dispatch2.dst == commit2.dst));

  // only the newest producer may clear busy
  assign tag_ok1 = cur_map[commit1.dst].tag == commit1.rrf_tag;
  assign tag_ok2 = cur_map[commit2.dst].tag == commit2.rrf_tag;

  assign clr1 = clear_en && commit1.valid && tag_ok1 && !hit1;
  assign clr2 = clear_en && commit2.valid && tag_ok2 && !hit2;

  always_comb begin
    next_map = cur_map;
    if (clr1) begin
      next_map[commit1.dst].busy = 1'b0;
    end
    if (clr2) begin
      next_map[commit2.dst].busy = 1'b0;
    end
    // port 2 applied last so it wins on the same reg
    if (set1) begin
      next_map[dispatch1.dst].busy = 1'b1;
      next_map[dispatch1.dst].tag  = dispatch1.rrf_tag;
    end
    if (set2) begin
      next_map[dispatch2.dst].busy = 1'b1;
      next_map[dispatch2.dst].tag  = dispatch2.rrf_tag;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      cur_map <= '0;
    end else if (load) begin
      cur_map <= load_map;  // checkpoint copy or recovery
    end else begin
      cur_map <= next_map;
    end
  end

endmodule

`default_nettype wire

// ==== src/rename_table.sv ====
`default_nettype none

module rename_table #(
  parameter int num_spec = 5
) (
  input  wire                         clk,
  input  wire                         reset,
  input  wire  arf_pkg::read_addrs_t  read_addrs,
  input  wire  arf_pkg::dispatch_t    dispatch1,
  input  wire  arf_pkg::dispatch_t    dispatch2,
  input  wire  arf_pkg::commit_t      commit1,
  input  wire  arf_pkg::commit_t      commit2,
  input  wire  arf_pkg::branch_res_t  branch,
  output arf_pkg::rrf_tag_t           tag1,
  output arf_pkg::rrf_tag_t           tag2,
  output arf_pkg::rrf_tag_t           tag3,
  output arf_pkg::rrf_tag_t           tag4,
  output logic                        busy1,
  output logic                        busy2,
  output logic                        busy3,
  output logic                        busy4
);

  localparam int num_copies = num_spec + 1;  // index 0 is the master

  arf_pkg::map_state_t cur_maps  [num_copies];
  arf_pkg::map_state_t next_maps [num_copies];
  arf_pkg::map_state_t miss_map;
  arf_pkg::map_state_t master;

  logic no_branch;
  logic is_success;
  logic is_miss;
  logic clear_en;

  assign no_branch  = branch.kind == arf_pkg::br_none;
  assign is_success = branch.kind == arf_pkg::br_success;
  assign is_miss    = branch.kind == arf_pkg::br_miss;
  assign clear_en   = !is_miss;  // recovery overrides commit clears

  // one-hot select of the checkpoint to restore
  always_comb begin
    miss_map = '0;
    for (int j = 0; j < num_spec; j++) begin
      if (branch.tag[j]) begin
        miss_map = miss_map | cur_maps[j+1];
      end
    end
  end

  for (genvar i = 0; i < num_copies; i++) begin : g_copy
    logic [1:0]          set_en;
    logic                load;
    arf_pkg::map_state_t load_map;

    if (i == 0) begin : g_master
      assign set_en = {2{no_branch}};
      assign load   = is_miss;
    end else begin : g_ckpt
      // a checkpoint sees dispatches it was not taken before
      assign set_en = {~dispatch2.mpft_valid[i-1], ~dispatch1.mpft_valid[i-1]} &
                      {2{no_branch}};
      assign load   = is_miss || (is_success && branch.tag[i-1]);
    end

    assign load_map = is_miss ? miss_map : next_maps[0];

    rename_copy i_rename_copy (
      .clk      (clk),
      .reset    (reset),
      .dispatch1(dispatch1),
      .dispatch2(dispatch2),
      .set_en   (set_en),
      .commit1  (commit1),
      .commit2  (commit2),
      .clear_en (clear_en),
      .load     (load),
      .load_map (load_map),
      .cur_map  (cur_maps[i]),
      .next_map (next_maps[i])
    );
  end

  assign master = cur_maps[0];

  // operand lookups always from the master map
  assign tag1  = master[read_addrs.rs1_1].tag;
  assign tag2  = master[read_addrs.rs2_1].tag;
  assign tag3  = master[read_addrs.rs1_2].tag;
  assign tag4  = master[read_addrs.rs2_2].tag;

  assign busy1 = master[read_addrs.rs1_1].busy;
  assign busy2 = master[read_addrs.rs2_1].busy;
  assign busy3 = master[read_addrs.rs1_2].busy;
  assign busy4 = master[read_addrs.rs2_2].busy;

endmodule

`default_nettype wire

// ==== src/arf_top.sv ====
`default_nettype none

module arf_top #(
  parameter int num_spec = 5  // 1 to 8 checkpoints
) (
  input  wire                         clk,
  input  wire                         reset,
  input  wire  arf_pkg::read_addrs_t  read_addrs,
  input  wire  arf_pkg::commit_t      commit1,
  input  wire  arf_pkg::commit_t      commit2,
  input  wire  arf_pkg::dispatch_t    dispatch1,
  input  wire  arf_pkg::dispatch_t    dispatch2,
  input  wire  arf_pkg::branch_res_t  branch,
  output wire  arf_pkg::operand_t     op_rs1_1,
  output wire  arf_pkg::operand_t     op_rs2_1,
  output wire  arf_pkg::operand_t     op_rs1_2,
  output wire  arf_pkg::operand_t     op_rs2_2
);

  wire [arf_pkg::data_w-1:0] rdata1;
  wire [arf_pkg::data_w-1:0] rdata2;
  wire [arf_pkg::data_w-1:0] rdata3;
  wire [arf_pkg::data_w-1:0] rdata4;

  wire arf_pkg::rrf_tag_t tag1;
  wire arf_pkg::rrf_tag_t tag2;
  wire arf_pkg::rrf_tag_t tag3;
  wire arf_pkg::rrf_tag_t tag4;

  wire busy1;
  wire busy2;
  wire busy3;
  wire busy4;

  reg_file i_reg_file (
    .clk       (clk),
    .read_addrs(read_addrs),
    .commit1   (commit1),
    .commit2   (commit2),
    .rdata1    (rdata1),
    .rdata2    (rdata2),
    .rdata3    (rdata3),
    .rdata4    (rdata4)
  );

  rename_table #(
    .num_spec(num_spec)
  ) i_rename_table (
    .clk       (clk),
    .reset     (reset),
    .read_addrs(read_addrs),
    .dispatch1 (dispatch1),
    .dispatch2 (dispatch2),
    .commit1   (commit1),
    .commit2   (commit2),
    .branch    (branch),
    .tag1      (tag1),
    .tag2      (tag2),
    .tag3      (tag3),
    .tag4      (tag4),
    .busy1     (busy1),
    .busy2     (busy2),
    .busy3     (busy3),
    .busy4     (busy4)
  );

  // operand = committed value plus pending producer
  assign op_rs1_1 = '{data: rdata1, tag: tag1, busy: busy1};
  assign op_rs2_1 = '{data: rdata2, tag: tag2, busy: busy2};
  assign op_rs1_2 = '{data: rdata3, tag: tag3, busy: busy3};
  assign op_rs2_2 = '{data: rdata4, tag: tag4, busy: busy4};

endmodule

`default_nettype wire

// ==== sim/arf_chk.sv ====
`default_nettype none

module arf_chk #(
  parameter int num_spec = 5
) (
  input wire                         clk,
  input wire                         reset,
  input wire  arf_pkg::read_addrs_t  read_addrs,
  input wire  arf_pkg::branch_res_t  branch,
  input wire  arf_pkg::operand_t     op_rs1_1,
  input wire  arf_pkg::operand_t     op_rs2_1,
  input wire  arf_pkg::operand_t     op_rs1_2,
  input wire  arf_pkg::operand_t     op_rs2_2
);
  timeunit 1ns;
  timeprecision 1ps;

  int fail_count = 0;

  logic r0_bad;
  logic any_busy;

  assign r0_bad = (read_addrs.rs1_1 == '0 && op_rs1_1.data != '0) ||
                  (read_addrs.rs2_1 == '0 && op_rs2_1.data != '0) ||
                  (read_addrs.rs1_2 == '0 && op_rs1_2.data != '0) ||
                  (read_addrs.rs2_2 == '0 && op_rs2_2.data != '0);
  assign any_busy = op_rs1_1.busy || op_rs2_1.busy || op_rs1_2.busy || op_rs2_2.busy;

  a_zero_reg: assert property (@(posedge clk) !r0_bad)
    else begin
      $error("register 0 read returned nonzero data");
      fail_count++;
    end

  // only live checkpoints may be named
  a_branch_onehot: assert property (@(posedge clk) disable iff (reset)
    branch.kind != arf_pkg::br_none |->
      $onehot(branch.tag) && ((branch.tag >> num_spec) == '0))
    else begin
      $error("branch tag is not one-hot within the checkpoints");
      fail_count++;
    end

  a_reset_idle: assert property (@(posedge clk) $fell(reset) |-> !any_busy)
    else begin
      $error("busy output set right after reset");
      fail_count++;
    end

endmodule

bind arf_top arf_chk #(
  .num_spec(num_spec)
) i_arf_chk (
  .clk       (clk),
  .reset     (reset),
  .read_addrs(read_addrs),
  .branch    (branch),
  .op_rs1_1  (op_rs1_1),
  .op_rs2_1  (op_rs2_1),
  .op_rs1_2  (op_rs1_2),
  .op_rs2_2  (op_rs2_2)
);

`default_nettype wire

// ==== sim/arf_tb.sv ====
`default_nettype none

module arf_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int num_spec   = 5;
  localparam int num_copies = num_spec + 1;
  // reset, reset state, commits, dispatch, clears, checkpoints, random
  localparam int test_len   = 5 + 40 + 30 + 10 + 15 + 20 + 400;
  localparam int max_cycles = 2 * test_len;

  logic clk = 1'b0;
  logic reset;
  logic check_en;
  arf_pkg::read_addrs_t read_addrs;
  arf_pkg::commit_t     commit1;
  arf_pkg::commit_t     commit2;
  arf_pkg::dispatch_t   dispatch1;
  arf_pkg::dispatch_t   dispatch2;
  arf_pkg::branch_res_t branch;
  wire arf_pkg::operand_t op_rs1_1;
  wire arf_pkg::operand_t op_rs2_1;
  wire arf_pkg::operand_t op_rs1_2;
  wire arf_pkg::operand_t op_rs2_2;

  arf_pkg::map_state_t ref_map [num_copies];  // 0 is the master
  logic [31:0] ref_data [32];
  logic        ref_known [32];
  logic [31:0] rng = 32'd31155;
  int check_count = 0;
  int err_count = 0;
  int test_base = 0;
  int cycle_cnt = 0;

  always #10 clk = ~clk;

  arf_top #(
    .num_spec(num_spec)
  ) i_arf_top (
    .clk(clk), .reset(reset), .read_addrs(read_addrs),
    .commit1(commit1), .commit2(commit2),
    .dispatch1(dispatch1), .dispatch2(dispatch2), .branch(branch),
    .op_rs1_1(op_rs1_1), .op_rs2_1(op_rs2_1), .op_rs1_2(op_rs1_2), .op_rs2_2(op_rs2_2)
  );

  function automatic logic [31:0] xorshift(logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] fill(int r);
    return 32'h3c00_0000 ^ (r * 32'h0001_0811);
  endfunction

  // commit frees the entry only if it is still the newest producer
  function automatic logic commit_frees(arf_pkg::map_state_t cur, arf_pkg::commit_t c,
                                        logic v1, logic v2);
    return c.valid && (cur[c.dst].tag == c.rrf_tag) &&
           !(v1 && dispatch1.dst == c.dst) && !(v2 && dispatch2.dst == c.dst);
  endfunction

  function automatic arf_pkg::map_state_t copy_next(arf_pkg::map_state_t cur,
                                                    logic s1, logic s2);
    arf_pkg::map_state_t nxt;
    logic v1;
    logic v2;
    nxt = cur;
    v1 = s1 && dispatch1.valid;
    v2 = s2 && dispatch2.valid;
    if (commit_frees(cur, commit1, v1, v2)) nxt[commit1.dst].busy = 1'b0;
    if (commit_frees(cur, commit2, v1, v2)) nxt[commit2.dst].busy = 1'b0;
    if (v1) nxt[dispatch1.dst] = '{busy: 1'b1, tag: dispatch1.rrf_tag};
    if (v2) nxt[dispatch2.dst] = '{busy: 1'b1, tag: dispatch2.rrf_tag};  // port 2 last
    return nxt;
  endfunction

  function automatic arf_pkg::operand_t expect_op(arf_pkg::reg_idx_t r);
    arf_pkg::operand_t e;
    e.data = (r == 0) ? 32'd0 : ref_data[r];
    e.tag  = ref_map[0][r].tag;
    e.busy = ref_map[0][r].busy;
    return e;
  endfunction

  task automatic model_step;
    arf_pkg::map_state_t nxt [num_copies];
    logic no_br;
    no_br = (branch.kind == arf_pkg::br_none);
    if (commit1.valid && commit1.dst != 0) begin
      ref_data[commit1.dst] = commit1.data;
      ref_known[commit1.dst] = 1'b1;
    end
    if (commit2.valid && commit2.dst != 0) begin
      ref_data[commit2.dst] = commit2.data;
      ref_known[commit2.dst] = 1'b1;
    end
    if (branch.kind == arf_pkg::br_miss) begin
      for (int j = 0; j < num_spec; j++) begin
        if (branch.tag[j]) nxt[0] = ref_map[j+1];
      end
      for (int c = 1; c < num_copies; c++) nxt[c] = nxt[0];
    end else begin
      nxt[0] = copy_next(ref_map[0], no_br, no_br);
      for (int c = 1; c < num_copies; c++) begin
        nxt[c] = copy_next(ref_map[c], no_br && !dispatch1.mpft_valid[c-1],
                           no_br && !dispatch2.mpft_valid[c-1]);
        if (branch.kind == arf_pkg::br_success && branch.tag[c-1]) nxt[c] = nxt[0];
      end
    end
    for (int c = 0; c < num_copies; c++) ref_map[c] = nxt[c];
  endtask

  always @(posedge clk) begin
    if (reset) begin
      for (int c = 0; c < num_copies; c++) ref_map[c] = '0;
    end else begin
      model_step();
    end
  end

  task automatic check_val(string name, logic [31:0] got, logic [31:0] exp);
    check_count++;
    assert (got === exp) else begin
      $display("mismatch at %0t: %s got %0h expected %0h", $time, name, got, exp);
      err_count++;
    end
  endtask

  task automatic compare_op(string name, arf_pkg::operand_t got, arf_pkg::reg_idx_t r);
    arf_pkg::operand_t e;
    e = expect_op(r);
    if (r == 0 || ref_known[r]) check_val({name, ".data"}, got.data, e.data);
    check_val({name, ".tag"}, got.tag, e.tag);
    check_val({name, ".busy"}, got.busy, e.busy);
  endtask

  always @(negedge clk) begin
    if (check_en) begin
      compare_op("op_rs1_1", op_rs1_1, read_addrs.rs1_1);
      compare_op("op_rs2_1", op_rs2_1, read_addrs.rs2_1);
      compare_op("op_rs1_2", op_rs1_2, read_addrs.rs1_2);
      compare_op("op_rs2_2", op_rs2_2, read_addrs.rs2_2);
    end
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= max_cycles) begin
      $display("timeout: run did not end within %0d cycles", max_cycles);
      $display("Testbench failed");
      $finish;
    end
  end

  task automatic set_idle;
    commit1 = '0;
    commit2 = '0;
    dispatch1 = '0;
    dispatch2 = '0;
    branch = '0;
    rng = xorshift(rng);
    read_addrs = rng[19:0];  // random reads every cycle
  endtask

  task automatic tick;
    @(posedge clk);
    #2;
    set_idle();
  endtask

  task automatic put_commit(int port, arf_pkg::reg_idx_t r, logic [31:0] d,
                            arf_pkg::rrf_tag_t t);
    if (port == 1) commit1 = '{valid: 1'b1, dst: r, data: d, rrf_tag: t};
    else commit2 = '{valid: 1'b1, dst: r, data: d, rrf_tag: t};
  endtask

  task automatic put_dispatch(int port, arf_pkg::reg_idx_t r, arf_pkg::rrf_tag_t t,
                              arf_pkg::spec_vec_t mpft);
    if (port == 1) dispatch1 = '{valid: 1'b1, dst: r, rrf_tag: t, mpft_valid: mpft};
    else dispatch2 = '{valid: 1'b1, dst: r, rrf_tag: t, mpft_valid: mpft};
  endtask

  task automatic put_branch(arf_pkg::br_kind_e kind, arf_pkg::spec_vec_t tag);
    branch = '{kind: kind, tag: tag};
    tick();
  endtask

  task automatic expect_reg(arf_pkg::reg_idx_t r, logic b, arf_pkg::rrf_tag_t t);
    read_addrs.rs2_2 = r;
    @(negedge clk);
    check_val("op_rs2_2.busy", op_rs2_2.busy, b);
    check_val("op_rs2_2.tag", op_rs2_2.tag, t);
    tick();
  endtask

  task automatic expect_data(arf_pkg::reg_idx_t r, logic [31:0] d);
    read_addrs.rs1_1 = r;
    @(negedge clk);
    check_val("op_rs1_1.data", op_rs1_1.data, d);
    tick();
  endtask

  task automatic random_cycle;
    rng = xorshift(rng);
    // narrow tag range so commits often hit the live producer
    commit1 = '{valid: rng[0], dst: rng[5:1], data: xorshift(rng ^ 32'h1),
                rrf_tag: {3'b000, rng[8:6]}};
    commit2 = '{valid: rng[9], dst: rng[14:10], data: xorshift(rng ^ 32'h2),
                rrf_tag: {3'b000, rng[17:15]}};
    rng = xorshift(rng);
    dispatch1 = '{valid: rng[0], dst: rng[5:1], rrf_tag: {3'b000, rng[8:6]},
                  mpft_valid: rng[16:9]};
    dispatch2 = '{valid: rng[17], dst: rng[22:18], rrf_tag: {3'b000, rng[25:23]},
                  mpft_valid: rng[31:24]};
    rng = xorshift(rng);
    if (rng[3:0] == 4'd0) branch.kind = arf_pkg::br_success;
    else if (rng[3:0] == 4'd1) branch.kind = arf_pkg::br_miss;
    if (branch.kind != arf_pkg::br_none) branch.tag = 8'd1 << (rng[15:8] % num_spec);
    tick();
  endtask

  task automatic end_test(string name);
    $display("test %s done: %0d errors", name, err_count - test_base);
    test_base = err_count;
  endtask

  initial begin
    for (int r = 0; r < 32; r++) ref_known[r] = 1'b0;
    reset = 1'b1;
    check_en = 1'b0;
    set_idle();
    repeat (5) @(posedge clk);
    #2;
    reset = 1'b0;
    check_en = 1'b1;

    for (int r = 0; r < 32; r++) expect_reg(r, 1'b0, 6'd0);
    end_test("reset state");

    for (int r = 1; r < 32; r += 2) begin
      put_commit(1, r, fill(r), 6'd0);
      if (r < 31) put_commit(2, r + 1, fill(r + 1), 6'd0);
      tick();
    end
    put_commit(1, 0, 32'hdead_beef, 6'd0);
    tick();
    expect_data(0, 32'd0);
    put_commit(1, 7, 32'h1111_1111, 6'd0);
    put_commit(2, 7, 32'h2222_2222, 6'd0);
    tick();
    expect_data(7, 32'h2222_2222);
    expect_data(12, fill(12));
    end_test("commit writes");

    put_dispatch(1, 3, 6'd10, 8'h00);
    tick();
    expect_reg(3, 1'b1, 6'd10);
    put_dispatch(1, 9, 6'd11, 8'h00);
    put_dispatch(2, 9, 6'd12, 8'h00);
    tick();
    expect_reg(9, 1'b1, 6'd12);
    end_test("dispatch");

    put_commit(1, 3, 32'h0000_0303, 6'd11);  // stale tag
    tick();
    expect_reg(3, 1'b1, 6'd10);
    put_commit(1, 3, 32'h0000_0303, 6'd10);
    tick();
    expect_reg(3, 1'b0, 6'd10);
    put_commit(2, 9, 32'h0000_0909, 6'd12);
    put_dispatch(1, 9, 6'd13, 8'h00);
    tick();
    expect_reg(9, 1'b1, 6'd13);
    put_commit(1, 9, 32'h0000_0909, 6'd13);
    tick();
    expect_reg(9, 1'b0, 6'd13);
    end_test("busy clear");

    put_dispatch(1, 4, 6'd20, 8'h04);
    tick();
    expect_reg(4, 1'b1, 6'd20);
    put_branch(arf_pkg::br_miss, 8'h04);
    expect_reg(4, 1'b0, 6'd0);
    put_dispatch(1, 5, 6'd21, 8'h00);
    put_dispatch(2, 6, 6'd22, 8'h04);
    tick();
    put_branch(arf_pkg::br_success, 8'h04);
    put_dispatch(1, 6, 6'd23, 8'h04);
    tick();
    expect_reg(6, 1'b1, 6'd23);
    put_branch(arf_pkg::br_miss, 8'h04);
    expect_reg(6, 1'b1, 6'd22);
    expect_reg(5, 1'b1, 6'd21);
    end_test("checkpoints");

    for (int n = 0; n < 400; n++) random_cycle();
    tick();
    end_test("random mix");

    $display("%0d checks, %0d errors, %0d assertion failures",
             check_count, err_count, i_arf_top.i_arf_chk.fail_count);
    if (err_count == 0 && i_arf_top.i_arf_chk.fail_count == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== all.f ====
src/arf_pkg.sv
src/reg_file.sv
src/rename_copy.sv
src/rename_table.sv
src/arf_top.sv
sim/arf_chk.sv
sim/arf_tb.sv
